// File: fcuCalc.sv
/*
  Flow-control result calculation
  Purely combinational. Decodes the opcode of an issued op and returns
  the cause code, link address, return target, redirect vector or wait
  completion flag. Unsupported forms return the poison word
*/
`include "flowCtl_macros.svh"

module fcuCalc
(
  input  flowCtlPkg::fcuIssue  op,
  input  logic                 waitDone,
  output logic [`FCU_WID-1:0]  result
);
  import flowCtlPkg::*;

  logic [5:0]          opcode;
  logic [`FCU_WID-1:0] causeVal;
  logic [`FCU_WID-1:0] retTarget;
  logic [`FCU_WID-1:0] rexTarget;
  logic [`FCU_WID-1:0] miscVal;

  // Both views share the opcode position
  assign opcode = op.instr.brFmt.opcode;

  // ========================================================================
  // Per-op values
  // ========================================================================

  // BRK cause merges the operand low byte with the encoded cause
  assign causeVal = {{(`FCU_WID-8){1'b0}}, op.a[7:0] | op.instr.brFmt.cause};

  // RTS target, immediate scaled by sixteen
  assign retTarget = op.a + {{(`FCU_WID-21){1'b0}}, op.instr.brFmt.imm, 4'h0};

  // REX redirect
  always_comb
  begin
    if (op.ol == `OL_USER)
    begin
      // Not allowed from user level
      rexTarget = `FCU_POISON;
    end
    else if (op.im < ~{op.ol, 2'b00})
    begin
      rexTarget = op.tvec;
    end
    else
    begin
      rexTarget = op.nextPc;
    end
  end

  // Misc group
  always_comb
  begin
    case (op.instr.miscFmt.funct5)
      // RTI is not handled here
      `F5_RTI:  miscVal = `FCU_POISON;
      `F5_WAIT: miscVal = {{(`FCU_WID-1){1'b0}}, waitDone};
      default:  miscVal = `FCU_POISON;
    endcase
  end

  // ========================================================================
  // Result select
  // ========================================================================

  always_comb
  begin
    case (opcode)
      `OP_BRK:   result = causeVal;
      // Link address for both jump forms
      `OP_JAL:   result = op.nextPc;
      `OP_JSR:   result = op.nextPc;
      `OP_RTS:   result = retTarget;
      `OP_REX:   result = rexTarget;
      `OP_BMISC: result = miscVal;
      default:   result = `FCU_POISON;
    endcase
  end

endmodule

// File: fcuSlot.sv
/*
  Flow-control execution slot
  Holds one issued op until its result has been taken by the writeback
  bus. WAIT ops count down from operand a before they complete, all
  other ops request the bus on the cycle after they are accepted
*/
`include "flowCtl_macros.svh"

module fcuSlot
#(
  parameter bit SLOT_ID = 1'b0
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 issueValid,
  input  flowCtlPkg::fcuIssue  issueData,
  output logic                 ready,
  output logic                 reqValid,
  output flowCtlPkg::fcuResult reqData,
  input  logic                 grant
);
  import flowCtlPkg::*;

  // Slot holds an op
  logic                busy;
  // Registered op
  fcuIssue             opQ;
  // WAIT countdown
  logic [`FCU_WID-1:0] waitCnt;
  logic                accept;
  logic                isWait;
  logic                waitDone;
  logic [`FCU_WID-1:0] calcResult;

  // ========================================================================
  // Issue side
  // ========================================================================

  // Free again the cycle after a grant
  assign ready = ~busy;
  assign accept = issueValid & ready;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy <= 1'b0;
    end
    else if (accept)
    begin
      busy <= 1'b1;
    end
    else if (grant)
    begin
      busy <= 1'b0;
    end
  end

  // Op payload, held stable while busy
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      opQ <= issueData;
    end
  end

  // ========================================================================
  // WAIT countdown
  // ========================================================================

  assign isWait = (opQ.instr.miscFmt.opcode == `OP_BMISC) &&
                  (opQ.instr.miscFmt.funct5 == `F5_WAIT);

  // Count of 0 or 1 means done
  assign waitDone = ~|waitCnt[`FCU_WID-1:1];

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      waitCnt <= issueData.a;
    end
    else if (busy && isWait && !waitDone)
    begin
      // Stops at one so the flag holds until granted
      waitCnt <= waitCnt - 1'b1;
    end
  end

  // ========================================================================
  // Result and bus request
  // ========================================================================

  fcuCalc calc
  (
    .op       (opQ),
    .waitDone (waitDone),
    .result   (calcResult)
  );

  // All inputs are registered so the beat stays steady until granted
  assign reqValid = busy & (~isWait | waitDone);

  assign reqData = '{
    tag:    opQ.tag,
    slotId: SLOT_ID,
    value:  calcResult
  };

endmodule

// File: filelist.f
+incdir+.
flowCtlPkg.sv
fcuCalc.sv
fcuSlot.sv
resultBusArbiter.sv
flowCtlUnit.sv
flowCtl_checker.sv
flowCtlTb.sv

// File: flowCtlPkg.sv
/*
  Flow-control types
  Instruction word with its two decode views, the issued op carried into
  an execution slot, and the beat sent on the shared writeback bus
*/
`include "flowCtl_macros.svh"

package flowCtlPkg;

  // ========================================================================
  // Instruction views
  // ========================================================================

  // Branch format
  // Immediate is stored unscaled, the unit shifts it by four
  typedef struct packed {
    logic [16:0] imm;
    logic [7:0]  cause;
    logic [8:0]  rsvd;
    logic [5:0]  opcode;
  } fcuBrFmt;

  // Misc format, funct5 selects the sub-op
  typedef struct packed {
    logic [28:0] rsvd;
    logic [4:0]  funct5;
    logic [5:0]  opcode;
  } fcuMiscFmt;

  // Opcode sits in bits 5:0 of both views
  typedef union packed {
    fcuBrFmt   brFmt;
    fcuMiscFmt miscFmt;
  } fcuInstr;

  // ========================================================================
  // Pipeline payloads
  // ========================================================================

  // One issued op with every operand the calculation can need
  typedef struct packed {
    fcuInstr               instr;
    logic [`FCU_TAGW-1:0]  tag;
    // Operating level of the issuing context
    logic [1:0]            ol;
    // Current interrupt mask
    logic [3:0]            im;
    logic [`FCU_WID-1:0]   a;
    // Trap vector for REX
    logic [`FCU_WID-1:0]   tvec;
    logic [`FCU_AWID-1:0]  nextPc;
  } fcuIssue;

  // One writeback beat
  typedef struct packed {
    logic [`FCU_TAGW-1:0]  tag;
    // Which slot produced the value
    logic                  slotId;
    logic [`FCU_WID-1:0]   value;
  } fcuResult;

endpackage

// File: flowCtlTb.sv
/*
  Flow-control unit testbench
  Issues branch-class ops into the two-slot unit, predicts each beat
  from the instruction rules and scores every writeback transfer by tag
*/
`include "flowCtl_macros.svh"

module flowCtlTb;
  import flowCtlPkg::*;

  localparam int TAGS = 1 << `FCU_TAGW;
  localparam int OPS_PLANNED = 64;
  // Room for WAIT counts and random back-pressure per op
  localparam int WATCHDOG_CYCLES = 2000 + 40 * OPS_PLANNED;

  logic     clk;
  logic     reset;
  logic     issueValid;
  logic     issueReady;
  fcuIssue  issueData;
  logic     wbValid;
  logic     wbReady;
  fcuResult wbData;

  // Scoreboard indexed by tag
  logic [`FCU_WID-1:0] expVal [TAGS];
  logic                pending [TAGS];
  int                  acceptCycle [TAGS];
  int                  minLatency [TAGS];
  string               testName [TAGS];

  // WAIT counts for the directed latency ops
  int waitCounts [5] = '{0, 1, 2, 5, 12};

  logic [31:0]          rngState;
  logic [`FCU_TAGW-1:0] nextTag;
  logic [`FCU_TAGW-1:0] beatTag;
  int cycle = 0;
  int mismatches = 0;
  int otherErrors = 0;
  int opsIssued = 0;
  int beatsSeen = 0;
  int retired = 0;
  // Selects always ready (0), stalled (1) or random (2) wbReady
  int readyMode = 0;

  flowCtlUnit DUT (.clk(clk), .reset(reset), .issueValid(issueValid), .issueReady(issueReady),
    .issueData(issueData), .wbValid(wbValid), .wbReady(wbReady), .wbData(wbData));

  bind flowCtlUnit flowCtl_checker chk (.clk(clk), .reset(reset), .issueReady(issueReady),
    .wbValid(wbValid), .wbReady(wbReady), .wbData(wbData), .reqData0(reqData[0]),
    .reqData1(reqData[1]), .reqValid(reqValid), .grant(grant));

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] randWord();
    rngState = rngState * 32'd1103515245 + 32'd12345;
    return rngState;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = randWord();
    return {hi, randWord()};
  endfunction

  // ==========================================================================
  // Reference rules
  // ==========================================================================

  function automatic logic [`FCU_WID-1:0] predictResult(fcuIssue op);
    logic [5:0] opc;
    logic [3:0] maskLimit;
    opc = op.instr.brFmt.opcode;
    // Complement of the level with two zero bits appended
    maskLimit = ~{op.ol, 2'b00};
    if (opc == `OP_BRK)
      return op.a[7:0] | op.instr.brFmt.cause;
    if (opc == `OP_JAL || opc == `OP_JSR)
      return op.nextPc;
    if (opc == `OP_RTS)
      return op.a + ({{(`FCU_WID-17){1'b0}}, op.instr.brFmt.imm} << 4);
    if (opc == `OP_REX && op.ol != `OL_USER)
      return (op.im < maskLimit) ? op.tvec : op.nextPc;
    if (opc == `OP_BMISC && op.instr.miscFmt.funct5 == `F5_WAIT)
      return 1;
    return `FCU_POISON;
  endfunction

  // Step to the falling edge and update wbReady
  task automatic tickNegedge();
    logic [31:0] r;
    @(negedge clk);
    r = randWord();
    // Random mode is ready about three times in four
    wbReady = (readyMode == 0) || (readyMode == 2 && (r[13] || r[27]));
  endtask

  task automatic sendOp(input logic [5:0] opcode, input logic [4:0] funct5,
                        input logic [1:0] ol, input logic [63:0] a, input string name);
    fcuIssue op;
    logic [31:0] r;
    r = randWord();
    op.instr.brFmt.imm = r[16:0];
    op.instr.brFmt.cause = r[31:24];
    op.instr.brFmt.rsvd = '0;
    op.instr.brFmt.opcode = opcode;
    if (opcode == `OP_BMISC)
      op.instr.miscFmt.funct5 = funct5;
    op.tag = nextTag;
    op.ol = ol;
    op.im = r[20:17];
    op.a = a;
    op.tvec = rand64();
    op.nextPc = rand64();
    nextTag = nextTag + 1'b1;
    tickNegedge();
    issueValid = 1'b1;
    issueData = op;
    while (!issueReady)
      tickNegedge();
    if (pending[op.tag])
    begin
      $display("Tag %0d issued again while its result was still pending", op.tag);
      otherErrors++;
    end
    // Accepted at the coming rising edge
    expVal[op.tag] = predictResult(op);
    pending[op.tag] = 1'b1;
    acceptCycle[op.tag] = cycle;
    // WAIT n ends no earlier than n-1 cycles after acceptance
    minLatency[op.tag] = (opcode == `OP_BMISC && funct5 == `F5_WAIT && a > 1) ?
                         int'(a[15:0]) - 1 : 1;
    testName[op.tag] = name;
    opsIssued++;
    @(posedge clk);
  endtask

  task automatic drainBeats();
    tickNegedge();
    issueValid = 1'b0;
    while (retired != opsIssued)
      tickNegedge();
  endtask

  // ==========================================================================
  // Writeback monitor
  // ==========================================================================

  always @(posedge clk)
  begin
    if (!reset && wbValid && wbReady)
    begin
      beatsSeen++;
      beatTag = wbData.tag;
      if (!pending[beatTag])
      begin
        $display("Beat with tag %0d arrived with no op pending for it", beatTag);
        otherErrors++;
      end
      else
      begin
        assert (wbData.value == expVal[beatTag])
        else
        begin
          $display("MISMATCH %s: expected %h, actual %h",
                   testName[beatTag], expVal[beatTag], wbData.value);
          mismatches++;
        end
        assert (cycle - acceptCycle[beatTag] >= minLatency[beatTag])
        else
        begin
          $display("MISMATCH %s latency: expected >= %0d, actual %0d", testName[beatTag],
                   minLatency[beatTag], cycle - acceptCycle[beatTag]);
          mismatches++;
        end
        pending[beatTag] = 1'b0;
        retired++;
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d ops retired",
             WATCHDOG_CYCLES, retired, opsIssued);
    $display("Verification failed");
    $finish;
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial
  begin
    logic [31:0] r;
    rngState = 32'd98;
    nextTag = '0;
    reset = 1'b1;
    issueValid = 1'b0;
    issueData = '0;
    wbReady = 1'b0;
    for (int i = 0; i < TAGS; i++)
      pending[i] = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    sendOp(`OP_BRK, 5'h0, 2'd0, rand64(), "brk");
    sendOp(`OP_JAL, 5'h0, 2'd1, rand64(), "jal");
    sendOp(`OP_JSR, 5'h0, 2'd2, rand64(), "jsr");
    sendOp(`OP_RTS, 5'h0, 2'd3, rand64(), "rts");
    // Every level with a random mask
    for (int lvl = 0; lvl < 4; lvl++)
      repeat (3) sendOp(`OP_REX, 5'h0, lvl[1:0], rand64(), "rex");
    sendOp(`OP_BMISC, `F5_RTI, 2'd0, rand64(), "rti");
    sendOp(`OP_BMISC, 5'h02, 2'd0, rand64(), "miscUndef");
    sendOp(6'h2A, 5'h0, 2'd0, rand64(), "opUndef");
    foreach (waitCounts[i])
      sendOp(`OP_BMISC, `F5_WAIT, 2'd0, 64'(waitCounts[i]), "wait");
    drainBeats();

    // Both slots fill behind a stalled bus
    readyMode = 1;
    sendOp(`OP_JAL, 5'h0, 2'd0, rand64(), "stallJal");
    sendOp(`OP_BMISC, `F5_WAIT, 2'd0, 64'd3, "stallWait");
    tickNegedge();
    assert (!issueReady)
    else
    begin
      $display("issueReady stayed high with both slots full");
      otherErrors++;
    end
    repeat (6) tickNegedge();
    readyMode = 0;
    drainBeats();

    // Both slots requesting at once
    readyMode = 1;
    sendOp(`OP_BRK, 5'h0, 2'd0, rand64(), "rrBrk");
    sendOp(`OP_RTS, 5'h0, 2'd0, rand64(), "rrRts");
    repeat (2) tickNegedge();
    readyMode = 0;
    drainBeats();

    readyMode = 2;
    repeat (36)
    begin
      r = randWord();
      case (r[18:16])
        3'd0: sendOp(`OP_BRK, 5'h0, r[5:4], rand64(), "rndBrk");
        3'd1: sendOp(`OP_JAL, 5'h0, r[5:4], rand64(), "rndJal");
        3'd2: sendOp(`OP_JSR, 5'h0, r[5:4], rand64(), "rndJsr");
        3'd3: sendOp(`OP_RTS, 5'h0, r[5:4], rand64(), "rndRts");
        3'd4: sendOp(`OP_REX, 5'h0, r[5:4], rand64(), "rndRex");
        3'd5: sendOp(`OP_BMISC, `F5_WAIT, r[5:4], 64'(r[10:8]), "rndWait");
        3'd6: sendOp(`OP_BMISC, `F5_RTI, r[5:4], rand64(), "rndRti");
        default: sendOp(6'h2A, 5'h0, r[5:4], rand64(), "rndUndef");
      endcase
    end
    readyMode = 0;
    drainBeats();

    if (beatsSeen != opsIssued)
    begin
      $display("MISMATCH beatCount: expected %0d, actual %0d", opsIssued, beatsSeen);
      mismatches++;
    end
    repeat (2) tickNegedge();
    $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatches, otherErrors, DUT.chk.failCount);
    if (mismatches + otherErrors + DUT.chk.failCount == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: flowCtlUnit.sv
/*
  Flow-control execution unit
  Two peer slots fed from one issue port, sharing one writeback port
  through a round-robin arbiter. Up to two ops can be in flight
*/
module flowCtlUnit
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 issueValid,
  output logic                 issueReady,
  input  flowCtlPkg::fcuIssue  issueData,
  output logic                 wbValid,
  input  logic                 wbReady,
  output flowCtlPkg::fcuResult wbData
);
  import flowCtlPkg::*;

  logic [1:0] slotReady;
  logic [1:0] slotIssueValid;
  logic [1:0] reqValid;
  logic [1:0] grant;
  fcuResult   reqData [1:0];

  // ========================================================================
  // Issue steering
  // ========================================================================

  // Slot 0 takes the op when free, slot 1 only when slot 0 is full
  assign slotIssueValid[0] = issueValid;
  assign slotIssueValid[1] = issueValid & ~slotReady[0];
  assign issueReady = |slotReady;

  fcuSlot #(.SLOT_ID(1'b0)) slot0
  (
    .clk        (clk),
    .reset      (reset),
    .issueValid (slotIssueValid[0]),
    .issueData  (issueData),
    .ready      (slotReady[0]),
    .reqValid   (reqValid[0]),
    .reqData    (reqData[0]),
    .grant      (grant[0])
  );

  fcuSlot #(.SLOT_ID(1'b1)) slot1
  (
    .clk        (clk),
    .reset      (reset),
    .issueValid (slotIssueValid[1]),
    .issueData  (issueData),
    .ready      (slotReady[1]),
    .reqValid   (reqValid[1]),
    .reqData    (reqData[1]),
    .grant      (grant[1])
  );

  // Shared writeback
  resultBusArbiter arbiter
  (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .reqData  (reqData),
    .grant    (grant),
    .wbValid  (wbValid),
    .wbData   (wbData),
    .wbReady  (wbReady)
  );

endmodule

// File: flowCtl_checker.sv
/*
  Flow-control handshake checker
  Bound into the top level. Covers the reset state, holding under
  back-pressure, single grant and round-robin order on the shared bus
*/
module flowCtl_checker
(
  input logic                 clk,
  input logic                 reset,
  input logic                 issueReady,
  input logic                 wbValid,
  input logic                 wbReady,
  input flowCtlPkg::fcuResult wbData,
  input flowCtlPkg::fcuResult reqData0,
  input flowCtlPkg::fcuResult reqData1,
  input logic [1:0]           reqValid,
  input logic [1:0]           grant
);

  int failCount = 0;
  // Slot that moved the last beat
  logic lastSlot;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // Slot 0 goes first out of reset
      lastSlot <= 1'b1;
    end
    else if (wbValid && wbReady)
    begin
      lastSlot <= wbData.slotId;
    end
  end

  // ==========================================================================
  // Bus and slot properties
  // ==========================================================================

  resetState: assert property (@(posedge clk) reset |=> !wbValid && issueReady)
  else
  begin
    $error("Bus busy or issue blocked after reset");
    failCount++;
  end

  // Offered beat stays until taken
  stallHold: assert property (@(posedge clk) disable iff (reset)
    wbValid && !wbReady |=> wbValid)
  else
  begin
    $error("Writeback beat withdrawn under back-pressure");
    failCount++;
  end

  slot0Hold: assert property (@(posedge clk) disable iff (reset)
    reqValid[0] && !grant[0] |=> reqValid[0] && $stable(reqData0))
  else
  begin
    $error("Slot 0 request changed before its grant");
    failCount++;
  end

  slot1Hold: assert property (@(posedge clk) disable iff (reset)
    reqValid[1] && !grant[1] |=> reqValid[1] && $stable(reqData1))
  else
  begin
    $error("Slot 1 request changed before its grant");
    failCount++;
  end

  oneGrant: assert property (@(posedge clk) disable iff (reset)
    $onehot0(grant) && (!(|grant) || (wbValid && wbReady)))
  else
  begin
    $error("Grant without an accepted beat, or two grants");
    failCount++;
  end

  // With both slots waiting, the one that did not go last wins
  roundRobin: assert property (@(posedge clk) disable iff (reset)
    (&reqValid) && wbReady |-> grant[~lastSlot])
  else
  begin
    $error("Round-robin order broken between slots");
    failCount++;
  end

endmodule

// File: flowCtl_macros.svh
/*
  Flow-control unit constants
  Data and address widths, opcode and funct5 encodings, the user
  operating level and the poison fill word used for unsupported ops
*/
`ifndef FLOWCTL_MACROS_SVH
`define FLOWCTL_MACROS_SVH

// ==========================================================================
// Widths
// ==========================================================================

// Result and operand width
`define FCU_WID 64
// Program counter width
`define FCU_AWID 64
// Issue tag, enough for a small reorder window
`define FCU_TAGW 4

// ==========================================================================
// Encodings
// ==========================================================================

// Branch-class opcodes, low six bits of the instruction word
`define OP_BRK 6'h00
`define OP_JAL 6'h18
`define OP_JSR 6'h19
`define OP_RTS 6'h1A
`define OP_REX 6'h1B
`define OP_BMISC 6'h1C

// Sub-ops of the misc group
`define F5_RTI 5'h13
`define F5_WAIT 5'h14

// Lowest privilege level
`define OL_USER 2'd3

// Returned for ops this unit cannot complete
`define FCU_POISON {(`FCU_WID/4){4'hC}}

`endif

// File: resultBusArbiter.sv
/*
  Writeback bus arbiter
  Round-robin choice between the two slots. The winner's beat goes onto
  the bus in the same cycle and its grant is raised only when the bus
  accepts the transfer
*/
module resultBusArbiter
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [1:0]           reqValid,
  input  flowCtlPkg::fcuResult reqData [1:0],
  output logic [1:0]           grant,
  output logic                 wbValid,
  output flowCtlPkg::fcuResult wbData,
  input  logic                 wbReady
);

  // Slot that won the last transfer
  logic lastWinner;
  // Slot currently selected
  logic pick;

  // Slot 1 goes when slot 0 is idle or slot 0 went last
  assign pick = reqValid[1] & (~reqValid[0] | ~lastWinner);

  // Bus mux
  assign wbValid = |reqValid;
  assign wbData = reqData[pick];

  // At most one grant, and only on an accepted beat
  assign grant[0] = wbReady & reqValid[0] & ~pick;
  assign grant[1] = wbReady & reqValid[1] & pick;

  // Priority flips after every transfer
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // Slot 0 first out of reset
      lastWinner <= 1'b1;
    end
    else if (wbValid && wbReady)
    begin
      lastWinner <= pick;
    end
  end

endmodule
